// File: hw/isa_pkg.sv
// Only the RV32 register fields are decoded here; four issue classes cover every instruction
package isa_pkg;

    // Machine word and register index
    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;

    // Issue class, set by the decoder ahead of this stage
    typedef enum logic [1:0]
    {
        CLASS_ALU   = 2'd0,
        CLASS_LOAD  = 2'd1,
        CLASS_STORE = 2'd2,
        CLASS_MUL   = 2'd3
    } instr_class_e;

    // Register fields inside an instruction word
    localparam int RD_LSB = 7;
    localparam int RA_LSB = 15;
    localparam int RB_LSB = 20;

    // PC step per instruction
    localparam int INSTR_BYTES = 4;

endpackage

// File: hw/issue_pkg.sv
// Loads and multiplies finish in E2; with a bypass option off their users wait for writeback
package issue_pkg;
    import isa_pkg::*;

    // One word from the fetch unit
    typedef struct packed
    {
        logic         valid;
        xlen_t        instr;
        xlen_t        pc;
        instr_class_e iclass;
        logic         rd_valid;
    } fetch_word_t;

    // One issue slot, operands filled in at the top level
    typedef struct packed
    {
        logic         valid;
        instr_class_e iclass;
        xlen_t        opcode;
        xlen_t        pc;
        reg_idx_t     rd;
        reg_idx_t     ra;
        reg_idx_t     rb;
        xlen_t        ra_value;
        xlen_t        rb_value;
    } issue_op_t;

    // State of one pipe stage
    typedef struct packed
    {
        logic         valid;
        instr_class_e iclass;
        reg_idx_t     rd;
        logic         rd_valid;
        xlen_t        pc;
        xlen_t        result;
    } stage_t;

    localparam bit    EN_DUAL_ISSUE  = 1'b1;
    localparam bit    EN_LOAD_BYPASS = 1'b1;
    localparam bit    EN_MUL_BYPASS  = 1'b1;
    localparam xlen_t RESET_PC       = 32'h0000_0000;

    // Op leaves a value in the register file
    function automatic logic writes_rd(issue_op_t op);
        return op.valid && (op.iclass != CLASS_STORE) && (op.rd != '0);
    endfunction

endpackage

// File: hw/fetch_select.sv
// PCs are compared in full; word 1 is taken to follow word 0 whenever word 0 is in sequence
`timescale 1ns/1ps

module fetch_select
    import isa_pkg::*;
    import issue_pkg::*;
(
     input  logic        clk_i
    ,input  logic        rst_i
    ,input  fetch_word_t fetch0_i
    ,input  fetch_word_t fetch1_i
    ,input  logic        issue0_i
    ,input  logic        issue1_i
    ,output issue_op_t   cand0_o
    ,output issue_op_t   cand1_o
    ,output logic        fetch0_accept_o
    ,output logic        fetch1_accept_o
    ,output logic        branch_request_o
    ,output xlen_t       branch_pc_o
);

    xlen_t pc_q;
    logic  match0;
    logic  match1;

    // Fetch word to candidate, operands left empty
    function automatic issue_op_t to_cand(fetch_word_t w);
        issue_op_t op;
        op        = '0;
        op.valid  = w.valid;
        op.iclass = w.iclass;
        op.opcode = w.instr;
        op.pc     = w.pc;
        op.ra     = w.instr[RA_LSB +: $bits(reg_idx_t)];
        op.rb     = w.instr[RB_LSB +: $bits(reg_idx_t)];
        // No destination unless the decoder flagged one
        op.rd     = w.rd_valid ? w.instr[RD_LSB +: $bits(reg_idx_t)] : '0;
        return op;
    endfunction

    //------------------------------------------------------------------------
    // Expected PC
    //------------------------------------------------------------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            pc_q <= RESET_PC;
        else if (issue1_i)
            pc_q <= pc_q + xlen_t'(2 * INSTR_BYTES);
        else if (issue0_i)
            pc_q <= pc_q + xlen_t'(INSTR_BYTES);
    end

    assign match0 = fetch0_i.valid && (fetch0_i.pc == pc_q);
    assign match1 = fetch1_i.valid && (fetch1_i.pc == pc_q);

    //------------------------------------------------------------------------
    // Slot selection
    //------------------------------------------------------------------------
    always_comb
    begin
        cand0_o = '0;
        cand1_o = '0;
        if (match0)
        begin
            cand0_o = to_cand(fetch0_i);
            cand1_o = to_cand(fetch1_i);
        end
        else if (match1)
            cand0_o = to_cand(fetch1_i);
    end

    // Nothing in sequence, ask fetch to restart at the expected PC
    assign branch_request_o = !match0 && !match1 && (fetch0_i.valid || fetch1_i.valid);
    assign branch_pc_o      = pc_q;

    // Stale word 0 is dropped when word 1 issues from candidate 0
    assign fetch0_accept_o = issue0_i && (match0 || match1);
    assign fetch1_accept_o = (issue0_i && !match0 && match1) || issue1_i;

endmodule

// File: hw/issue_scheduler.sv
// One load-store unit and one multiplier; slot 1 only issues alongside slot 0
`timescale 1ns/1ps

module issue_scheduler
    import isa_pkg::*;
    import issue_pkg::*;
(
     input  issue_op_t cand0_i
    ,input  issue_op_t cand1_i
    ,input  logic      lsu_stall_i
    ,input  stage_t    p0_e1_i
    ,input  stage_t    p0_e2_i
    ,input  stage_t    p1_e1_i
    ,input  stage_t    p1_e2_i
    ,output logic      issue0_o
    ,output logic      issue1_o
    ,output issue_op_t slot0_o
    ,output issue_op_t slot1_o
);

    logic [31:0] sb0;
    logic [31:0] sb1;
    logic        lsu_e1;
    logic        mul_block;
    logic        pair_ok;

    // Stage holds a result that cannot be forwarded yet
    function automatic logic pending(stage_t s, logic chk_load, logic chk_mul);
        return s.valid && s.rd_valid &&
               ((chk_load && (s.iclass == CLASS_LOAD)) || (chk_mul && (s.iclass == CLASS_MUL)));
    endfunction

    function automatic logic blocked(logic [31:0] sb, issue_op_t op);
        return sb[op.ra] || sb[op.rb] || sb[op.rd];
    endfunction

    //------------------------------------------------------------------------
    // Scoreboard
    //------------------------------------------------------------------------
    always_comb
    begin
        sb0 = '0;
        if (pending(p0_e2_i, !EN_LOAD_BYPASS, !EN_MUL_BYPASS))
            sb0[p0_e2_i.rd] = 1'b1;
        if (pending(p1_e2_i, !EN_LOAD_BYPASS, !EN_MUL_BYPASS))
            sb0[p1_e2_i.rd] = 1'b1;
        // Loads and multiplies in E1 have no result yet
        if (pending(p0_e1_i, 1'b1, 1'b1))
            sb0[p0_e1_i.rd] = 1'b1;
        if (pending(p1_e1_i, 1'b1, 1'b1))
            sb0[p1_e1_i.rd] = 1'b1;
    end

    // Multiply waits one cycle behind a memory op
    assign lsu_e1 = (p0_e1_i.valid && (p0_e1_i.iclass inside {CLASS_LOAD, CLASS_STORE})) ||
                    (p1_e1_i.valid && (p1_e1_i.iclass inside {CLASS_LOAD, CLASS_STORE}));
    assign mul_block = lsu_e1 && (cand0_i.iclass == CLASS_MUL);

    assign issue0_o = cand0_i.valid && !lsu_stall_i && !mul_block && !blocked(sb0, cand0_i);

    // Slot 1 also sees slot 0's destination
    always_comb
    begin
        sb1 = sb0;
        if (issue0_o && writes_rd(cand0_i))
            sb1[cand0_i.rd] = 1'b1;
    end

    //------------------------------------------------------------------------
    // Pairing
    //------------------------------------------------------------------------
    always_comb
    begin
        case (cand1_i.iclass)
            CLASS_ALU:   pair_ok = 1'b1;
            CLASS_LOAD,
            CLASS_STORE: pair_ok = cand0_i.iclass inside {CLASS_ALU, CLASS_MUL};
            default:     pair_ok = cand0_i.iclass inside {CLASS_ALU, CLASS_LOAD, CLASS_STORE};
        endcase
    end

    assign issue1_o = issue0_o && EN_DUAL_ISSUE && cand1_i.valid && pair_ok &&
                      !blocked(sb1, cand1_i);

    always_comb
    begin
        slot0_o       = cand0_i;
        slot0_o.valid = issue0_o;
        slot1_o       = cand1_i;
        slot1_o.valid = issue1_o;
    end

endmodule

// File: hw/pipe_ctrl.sv
// Results are taken as they arrive; the E2 load and multiply buses are shared by both pipes
`timescale 1ns/1ps

module pipe_ctrl
    import isa_pkg::*;
    import issue_pkg::*;
(
     input  logic      clk_i
    ,input  logic      rst_i
    ,input  issue_op_t issue_i
    ,input  xlen_t     alu_value_i
    ,input  xlen_t     mem_value_i
    ,input  xlen_t     mul_value_i
    ,output stage_t    e1_o
    ,output stage_t    e2_o
    ,output stage_t    wb_o
);

    stage_t e1_next;
    stage_t e1_q;
    stage_t e2_q;
    stage_t wb_q;

    // Issued op in stage form, stores carry no destination
    always_comb
    begin
        e1_next          = '0;
        e1_next.valid    = issue_i.valid;
        e1_next.iclass   = issue_i.iclass;
        e1_next.rd       = issue_i.rd;
        e1_next.rd_valid = writes_rd(issue_i);
        e1_next.pc       = issue_i.pc;
    end

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            e1_q <= '0;
            e2_q <= '0;
            wb_q <= '0;
        end
        else
        begin
            e1_q <= e1_next;
            e2_q <= e1_o;
            wb_q <= e2_o;
        end
    end

    // E1 result is the live ALU output
    always_comb
    begin
        e1_o        = e1_q;
        e1_o.result = alu_value_i;
    end

    // Long-latency units overwrite the ALU value
    always_comb
    begin
        e2_o = e2_q;
        case (e2_q.iclass)
            CLASS_LOAD: e2_o.result = mem_value_i;
            CLASS_MUL:  e2_o.result = mul_value_i;
            default:    e2_o.result = e2_q.result;
        endcase
    end

    assign wb_o = wb_q;

endmodule

// File: hw/regfile.sv
// x0 is never written; reads are asynchronous and return the old value in a write cycle
`timescale 1ns/1ps

module regfile
    import isa_pkg::*;
    import issue_pkg::*;
(
     input  logic     clk_i
    ,input  logic     rst_i
    ,input  stage_t   wr0_i
    ,input  stage_t   wr1_i
    ,input  reg_idx_t ra0_i
    ,input  reg_idx_t rb0_i
    ,input  reg_idx_t ra1_i
    ,input  reg_idx_t rb1_i
    ,output xlen_t    ra0_value_o
    ,output xlen_t    rb0_value_o
    ,output xlen_t    ra1_value_o
    ,output xlen_t    rb1_value_o
);

    xlen_t regs_q [32];
    logic  wr0_en;
    logic  wr1_en;

    assign wr0_en = wr0_i.valid && wr0_i.rd_valid && (wr0_i.rd != '0);
    assign wr1_en = wr1_i.valid && wr1_i.rd_valid && (wr1_i.rd != '0);

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            for (int i = 0; i < 32; i++)
                regs_q[i] <= '0;
        end
        else
        begin
            if (wr0_en)
                regs_q[wr0_i.rd] <= wr0_i.result;
            // Pipe 1 is younger, last write wins
            if (wr1_en)
                regs_q[wr1_i.rd] <= wr1_i.result;
        end
    end

    assign ra0_value_o = regs_q[ra0_i];
    assign rb0_value_o = regs_q[rb0_i];
    assign ra1_value_o = regs_q[ra1_i];
    assign rb1_value_o = regs_q[rb1_i];

endmodule

// File: hw/operand_bypass.sv
// Forwarded E1 values are ALU results; the scheduler keeps load and multiply users back
`timescale 1ns/1ps

module operand_bypass
    import isa_pkg::*;
    import issue_pkg::*;
(
     input  reg_idx_t ra_i
    ,input  reg_idx_t rb_i
    ,input  xlen_t    ra_file_i
    ,input  xlen_t    rb_file_i
    ,input  stage_t   p0_e1_i
    ,input  stage_t   p0_e2_i
    ,input  stage_t   p0_wb_i
    ,input  stage_t   p1_e1_i
    ,input  stage_t   p1_e2_i
    ,input  stage_t   p1_wb_i
    ,input  xlen_t    exec0_value_i
    ,input  xlen_t    exec1_value_i
    ,output xlen_t    ra_value_o
    ,output xlen_t    rb_value_o
);

    function automatic logic hit(stage_t s, reg_idx_t idx);
        return s.valid && s.rd_valid && (s.rd == idx);
    endfunction

    // Oldest source first, each newer match overrides
    function automatic xlen_t resolve(reg_idx_t idx, xlen_t file_val);
        xlen_t val;
        val = file_val;
        if (hit(p0_wb_i, idx))
            val = p0_wb_i.result;
        if (hit(p1_wb_i, idx))
            val = p1_wb_i.result;
        if (hit(p0_e2_i, idx))
            val = p0_e2_i.result;
        if (hit(p1_e2_i, idx))
            val = p1_e2_i.result;
        if (hit(p0_e1_i, idx))
            val = exec0_value_i;
        if (hit(p1_e1_i, idx))
            val = exec1_value_i;
        // x0 reads as zero
        if (idx == '0)
            val = '0;
        return val;
    endfunction

    always_comb
    begin
        ra_value_o = resolve(ra_i, ra_file_i);
        rb_value_o = resolve(rb_i, rb_file_i);
    end

endmodule

// File: hw/issue_top.sv
// Result inputs must belong to the ops now in E1 and E2; unaccepted fetch words are held upstream
`timescale 1ns/1ps

module issue_top
    import isa_pkg::*;
    import issue_pkg::*;
(
     input  logic        clk_i
    ,input  logic        rst_i
    ,input  fetch_word_t fetch0_i
    ,input  fetch_word_t fetch1_i
    ,input  logic        lsu_stall_i
    ,input  xlen_t       exec0_value_i
    ,input  xlen_t       exec1_value_i
    ,input  xlen_t       mem_value_i
    ,input  xlen_t       mul_value_i
    ,output logic        fetch0_accept_o
    ,output logic        fetch1_accept_o
    ,output issue_op_t   slot0_o
    ,output issue_op_t   slot1_o
    ,output logic        branch_request_o
    ,output xlen_t       branch_pc_o
);

    issue_op_t cand0;
    issue_op_t cand1;
    issue_op_t sched0;
    issue_op_t sched1;
    logic      issue0;
    logic      issue1;
    stage_t    p0_e1;
    stage_t    p0_e2;
    stage_t    p0_wb;
    stage_t    p1_e1;
    stage_t    p1_e2;
    stage_t    p1_wb;
    xlen_t     ra0_file;
    xlen_t     rb0_file;
    xlen_t     ra1_file;
    xlen_t     rb1_file;
    xlen_t     ra0_value;
    xlen_t     rb0_value;
    xlen_t     ra1_value;
    xlen_t     rb1_value;

    //------------------------------------------------------------------------
    // Selection and scheduling
    //------------------------------------------------------------------------
    fetch_select u_fetch_select
    (
         .clk_i            (clk_i)
        ,.rst_i            (rst_i)
        ,.fetch0_i         (fetch0_i)
        ,.fetch1_i         (fetch1_i)
        ,.issue0_i         (issue0)
        ,.issue1_i         (issue1)
        ,.cand0_o          (cand0)
        ,.cand1_o          (cand1)
        ,.fetch0_accept_o  (fetch0_accept_o)
        ,.fetch1_accept_o  (fetch1_accept_o)
        ,.branch_request_o (branch_request_o)
        ,.branch_pc_o      (branch_pc_o)
    );

    issue_scheduler u_scheduler
    (
         .cand0_i     (cand0)
        ,.cand1_i     (cand1)
        ,.lsu_stall_i (lsu_stall_i)
        ,.p0_e1_i     (p0_e1)
        ,.p0_e2_i     (p0_e2)
        ,.p1_e1_i     (p1_e1)
        ,.p1_e2_i     (p1_e2)
        ,.issue0_o    (issue0)
        ,.issue1_o    (issue1)
        ,.slot0_o     (sched0)
        ,.slot1_o     (sched1)
    );

    //------------------------------------------------------------------------
    // Pipes
    //------------------------------------------------------------------------
    pipe_ctrl u_pipe0
    (
         .clk_i       (clk_i)
        ,.rst_i       (rst_i)
        ,.issue_i     (sched0)
        ,.alu_value_i (exec0_value_i)
        ,.mem_value_i (mem_value_i)
        ,.mul_value_i (mul_value_i)
        ,.e1_o        (p0_e1)
        ,.e2_o        (p0_e2)
        ,.wb_o        (p0_wb)
    );

    pipe_ctrl u_pipe1
    (
         .clk_i       (clk_i)
        ,.rst_i       (rst_i)
        ,.issue_i     (sched1)
        ,.alu_value_i (exec1_value_i)
        ,.mem_value_i (mem_value_i)
        ,.mul_value_i (mul_value_i)
        ,.e1_o        (p1_e1)
        ,.e2_o        (p1_e2)
        ,.wb_o        (p1_wb)
    );

    //------------------------------------------------------------------------
    // Operands
    //------------------------------------------------------------------------
    regfile u_regfile
    (
         .clk_i       (clk_i)
        ,.rst_i       (rst_i)
        ,.wr0_i       (p0_wb)
        ,.wr1_i       (p1_wb)
        ,.ra0_i       (cand0.ra)
        ,.rb0_i       (cand0.rb)
        ,.ra1_i       (cand1.ra)
        ,.rb1_i       (cand1.rb)
        ,.ra0_value_o (ra0_file)
        ,.rb0_value_o (rb0_file)
        ,.ra1_value_o (ra1_file)
        ,.rb1_value_o (rb1_file)
    );

    operand_bypass u_bypass0
    (
         .ra_i          (cand0.ra)
        ,.rb_i          (cand0.rb)
        ,.ra_file_i     (ra0_file)
        ,.rb_file_i     (rb0_file)
        ,.p0_e1_i       (p0_e1)
        ,.p0_e2_i       (p0_e2)
        ,.p0_wb_i       (p0_wb)
        ,.p1_e1_i       (p1_e1)
        ,.p1_e2_i       (p1_e2)
        ,.p1_wb_i       (p1_wb)
        ,.exec0_value_i (exec0_value_i)
        ,.exec1_value_i (exec1_value_i)
        ,.ra_value_o    (ra0_value)
        ,.rb_value_o    (rb0_value)
    );

    operand_bypass u_bypass1
    (
         .ra_i          (cand1.ra)
        ,.rb_i          (cand1.rb)
        ,.ra_file_i     (ra1_file)
        ,.rb_file_i     (rb1_file)
        ,.p0_e1_i       (p0_e1)
        ,.p0_e2_i       (p0_e2)
        ,.p0_wb_i       (p0_wb)
        ,.p1_e1_i       (p1_e1)
        ,.p1_e2_i       (p1_e2)
        ,.p1_wb_i       (p1_wb)
        ,.exec0_value_i (exec0_value_i)
        ,.exec1_value_i (exec1_value_i)
        ,.ra_value_o    (ra1_value)
        ,.rb_value_o    (rb1_value)
    );

    // Issue slots with their operand values
    always_comb
    begin
        slot0_o          = sched0;
        slot0_o.ra_value = ra0_value;
        slot0_o.rb_value = rb0_value;
        slot1_o          = sched1;
        slot1_o.ra_value = ra1_value;
        slot1_o.rb_value = rb1_value;
    end

endmodule

// File: testbench/tb_model.svh
// Programs use x0..x7 only; every unit result is a fixed function of the op's PC
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Register values in program order, next PC to issue, and the held fetch pair
xlen_t       model_regs [32];
xlen_t       exp_pc;
fetch_word_t src0;
fetch_word_t src1;

// Values the execution units return for the op at a PC
function automatic xlen_t alu_result(xlen_t pc);
    return (pc * 32'h9E37_79B1) ^ 32'h00A5_5A00;
endfunction

function automatic xlen_t mem_result(xlen_t pc);
    return {pc[15:0], ~pc[15:0]} ^ 32'h5117_0000;
endfunction

function automatic xlen_t mul_result(xlen_t pc);
    return (pc + 32'd3) * (pc + 32'h0000_0101);
endfunction

function automatic xlen_t result_of(fetch_word_t w);
    case (w.iclass)
        CLASS_LOAD: return mem_result(w.pc);
        CLASS_MUL:  return mul_result(w.pc);
        default:    return alu_result(w.pc);
    endcase
endfunction

function automatic reg_idx_t reg_field(xlen_t instr, int lsb);
    return instr[lsb +: 5];
endfunction

// Destination as the issue slot shows it, zero for stores
function automatic reg_idx_t dest_of(fetch_word_t w);
    return w.rd_valid ? reg_field(w.instr, RD_LSB) : 5'd0;
endfunction

function automatic fetch_word_t random_word(xlen_t pc);
    fetch_word_t w;
    xlen_t       rd;
    xlen_t       ra;
    xlen_t       rb;
    rd         = xlen_t'($urandom_range(7, 0));
    ra         = xlen_t'($urandom_range(7, 0));
    rb         = xlen_t'($urandom_range(7, 0));
    w.valid    = 1'b1;
    w.pc       = pc;
    w.iclass   = instr_class_e'($urandom_range(3, 0));
    w.rd_valid = (w.iclass != CLASS_STORE);
    w.instr    = 32'h0000_0033 | (rd << RD_LSB) | (ra << RA_LSB) | (rb << RB_LSB);
    return w;
endfunction

task automatic new_pair(xlen_t base);
    src0 = random_word(base);
    src1 = random_word(base + 32'd4);
endtask

function automatic xlen_t model_value(reg_idx_t idx);
    return (idx == 5'd0) ? 32'd0 : model_regs[idx];
endfunction

// One op leaves the model in program order
task automatic retire_in_model(fetch_word_t w);
    if (w.iclass != CLASS_STORE && dest_of(w) != 5'd0)
        model_regs[dest_of(w)] = result_of(w);
    exp_pc = exp_pc + 32'd4;
endtask

task automatic check_equal(string name, xlen_t got, xlen_t exp);
    if (got !== exp)
    begin
        $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end_with_failure();
    end
endtask

`endif

// File: testbench/tb_issue.sv
// Seed 29; inputs change at the rising edge and all outputs are checked at the falling edge
`timescale 1ns/1ps

module tb_issue
    import isa_pkg::*;
    import issue_pkg::*;
();

    localparam int NUM_INSTR  = 400;
    localparam int MAX_CYCLES = 4000;
    localparam int IDLE_LIMIT = 64;

    logic        clk_i = 1'b0;
    logic        rst_i;
    fetch_word_t fetch0_i;
    fetch_word_t fetch1_i;
    logic        lsu_stall_i;
    xlen_t       exec0_value_i;
    xlen_t       exec1_value_i;
    xlen_t       mem_value_i;
    xlen_t       mul_value_i;
    logic        fetch0_accept_o;
    logic        fetch1_accept_o;
    issue_op_t   slot0_o;
    issue_op_t   slot1_o;
    logic        branch_request_o;
    xlen_t       branch_pc_o;

    // Current cycle's stimulus choices and slots issued 1 and 2 cycles back
    logic        stall_now;
    logic        inject_now;
    issue_op_t   d1_0;
    issue_op_t   d1_1;
    issue_op_t   d2_0;
    issue_op_t   d2_1;
    int          issued;
    int          cycles;
    int          idle;

    `include "tb_model.svh"

    always #2 clk_i = ~clk_i;

    issue_top issue_top_i
    (
         .clk_i            (clk_i)
        ,.rst_i            (rst_i)
        ,.fetch0_i         (fetch0_i)
        ,.fetch1_i         (fetch1_i)
        ,.lsu_stall_i      (lsu_stall_i)
        ,.exec0_value_i    (exec0_value_i)
        ,.exec1_value_i    (exec1_value_i)
        ,.mem_value_i      (mem_value_i)
        ,.mul_value_i      (mul_value_i)
        ,.fetch0_accept_o  (fetch0_accept_o)
        ,.fetch1_accept_o  (fetch1_accept_o)
        ,.slot0_o          (slot0_o)
        ,.slot1_o          (slot1_o)
        ,.branch_request_o (branch_request_o)
        ,.branch_pc_o      (branch_pc_o)
    );

    task automatic end_with_failure();
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    function automatic logic pair_allowed(instr_class_e c0, instr_class_e c1);
        case (c1)
            CLASS_ALU:   return 1'b1;
            CLASS_LOAD,
            CLASS_STORE: return (c0 == CLASS_ALU) || (c0 == CLASS_MUL);
            default:     return c0 != CLASS_MUL;
        endcase
    endfunction

    function automatic logic uses_reg(issue_op_t op, reg_idx_t r);
        return (op.ra == r) || (op.rb == r) || (op.rd == r);
    endfunction

    // Load or multiply from last cycle has no forwardable result yet
    function automatic logic long_hazard(issue_op_t prev, issue_op_t op);
        return prev.valid && (prev.iclass inside {CLASS_LOAD, CLASS_MUL}) &&
               (prev.rd != 5'd0) && uses_reg(op, prev.rd);
    endfunction

    //------------------------------------------------------------------------
    // Stimulus and result feeding
    //------------------------------------------------------------------------
    task automatic drive_cycle();
        xlen_t mem_v;
        xlen_t mul_v;
        mem_v = $urandom();
        mul_v = $urandom();
        if (d2_0.valid && d2_0.iclass == CLASS_LOAD)
            mem_v = mem_result(d2_0.pc);
        if (d2_1.valid && d2_1.iclass == CLASS_LOAD)
            mem_v = mem_result(d2_1.pc);
        if (d2_0.valid && d2_0.iclass == CLASS_MUL)
            mul_v = mul_result(d2_0.pc);
        if (d2_1.valid && d2_1.iclass == CLASS_MUL)
            mul_v = mul_result(d2_1.pc);
        stall_now  = ($urandom_range(7, 0) == 0);
        inject_now = ($urandom_range(15, 0) == 0);
        lsu_stall_i   <= stall_now;
        exec0_value_i <= d1_0.valid ? alu_result(d1_0.pc) : xlen_t'($urandom());
        exec1_value_i <= d1_1.valid ? alu_result(d1_1.pc) : xlen_t'($urandom());
        mem_value_i   <= mem_v;
        mul_value_i   <= mul_v;
        // A pair far from the expected PC for one cycle only
        if (inject_now)
        begin
            fetch0_i <= random_word(exp_pc + 32'h0000_1000);
            fetch1_i <= random_word(exp_pc + 32'h0000_1004);
        end
        else
        begin
            fetch0_i <= src0;
            fetch1_i <= src1;
        end
    endtask

    //------------------------------------------------------------------------
    // Checks
    //------------------------------------------------------------------------
    task automatic check_slot(string name, issue_op_t op);
        fetch_word_t w;
        w = (src0.valid && src0.pc == exp_pc) ? src0 : src1;
        check_equal({name, ".pc"}, op.pc, exp_pc);
        check_equal({name, ".opcode"}, op.opcode, w.instr);
        check_equal({name, ".iclass"}, op.iclass, w.iclass);
        check_equal({name, ".rd"}, op.rd, dest_of(w));
        check_equal({name, ".ra"}, op.ra, reg_field(w.instr, RA_LSB));
        check_equal({name, ".rb"}, op.rb, reg_field(w.instr, RB_LSB));
        check_equal({name, ".ra_value"}, op.ra_value, model_value(op.ra));
        check_equal({name, ".rb_value"}, op.rb_value, model_value(op.rb));
        check_equal({name, " load/mul hazard"},
                    long_hazard(d1_0, op) || long_hazard(d1_1, op), 1'b0);
        retire_in_model(w);
    endtask

    task automatic check_cycle();
        logic exp_acc0;
        logic exp_acc1;
        check_equal("branch_request_o", branch_request_o, inject_now);
        if (inject_now)
            check_equal("branch_pc_o", branch_pc_o, exp_pc);
        if (inject_now || stall_now)
            check_equal("slot0_o.valid", slot0_o.valid, 1'b0);
        check_equal("slot1_o.valid without slot0_o", slot1_o.valid && !slot0_o.valid, 1'b0);
        // Word 0 is dropped on every issue from candidate 0
        exp_acc0 = !inject_now && slot0_o.valid;
        // Word 1 moves to candidate 0 once word 0 has gone
        exp_acc1 = !inject_now && src1.valid &&
                   ((slot0_o.valid && !src0.valid) || slot1_o.valid);
        check_equal("fetch0_accept_o", fetch0_accept_o, exp_acc0);
        check_equal("fetch1_accept_o", fetch1_accept_o, exp_acc1);
        if (slot1_o.valid)
        begin
            check_equal("slot1_o class pair", pair_allowed(slot0_o.iclass, slot1_o.iclass), 1'b1);
            check_equal("slot1_o uses slot0_o.rd",
                        (slot0_o.rd != 5'd0) && uses_reg(slot1_o, slot0_o.rd), 1'b0);
        end
        if (slot0_o.valid)
            check_slot("slot0_o", slot0_o);
        if (slot1_o.valid)
            check_slot("slot1_o", slot1_o);
        if (exp_acc0)
            src0.valid = 1'b0;
        if (exp_acc1)
            src1.valid = 1'b0;
        if (!src0.valid && !src1.valid)
            new_pair(src1.pc + 32'd4);
        d2_0   = d1_0;
        d2_1   = d1_1;
        d1_0   = slot0_o;
        d1_1   = slot1_o;
        issued = issued + int'(slot0_o.valid) + int'(slot1_o.valid);
        idle   = slot0_o.valid ? 0 : idle + 1;
    endtask

    initial
    begin
        void'($urandom(29));
        rst_i         <= 1'b1;
        fetch0_i      <= '0;
        fetch1_i      <= '0;
        lsu_stall_i   <= 1'b0;
        exec0_value_i <= '0;
        exec1_value_i <= '0;
        mem_value_i   <= '0;
        mul_value_i   <= '0;
        stall_now  = 1'b0;
        inject_now = 1'b0;
        d1_0   = '0;
        d1_1   = '0;
        d2_0   = '0;
        d2_1   = '0;
        issued = 0;
        cycles = 0;
        idle   = 0;
        exp_pc = RESET_PC;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        check_equal("slot0_o.valid", slot0_o.valid, 1'b0);
        check_equal("slot1_o.valid", slot1_o.valid, 1'b0);
        check_equal("fetch0_accept_o", fetch0_accept_o, 1'b0);
        check_equal("fetch1_accept_o", fetch1_accept_o, 1'b0);
        check_equal("branch_request_o", branch_request_o, 1'b0);
        check_equal("branch_pc_o", branch_pc_o, RESET_PC);
        new_pair(RESET_PC);
        while (issued < NUM_INSTR)
        begin
            @(posedge clk_i);
            drive_cycle();
            @(negedge clk_i);
            check_cycle();
            cycles++;
            if (cycles >= MAX_CYCLES || idle >= IDLE_LIMIT)
            begin
                $display("Timeout: %0d of %0d instructions issued in %0d cycles",
                         issued, NUM_INSTR, cycles);
                end_with_failure();
            end
        end
        $display("Test passed");
        $finish;
    end

endmodule

// File: sim.f
+incdir+testbench
hw/isa_pkg.sv
hw/issue_pkg.sv
hw/fetch_select.sv
hw/issue_scheduler.sv
hw/pipe_ctrl.sv
hw/regfile.sv
hw/operand_bypass.sv
hw/issue_top.sv
testbench/tb_issue.sv
